//--- addr_decode.sv
// --------------------------------------
// stage 1: registers the cpu request and
// classifies its address into region and
// i/o register; also drives the cartridge
// strobes straight off the stage register
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
	input  wire                          clk_cpu,
	input  wire                          reset,
	input  wire [gb_io_pkg::ADDR_W-1:0]  cpu_addr,
	input  wire [gb_io_pkg::DATA_W-1:0]  cpu_wdata,
	input  wire                          cpu_rd,
	input  wire                          cpu_wr,
	input  wire                          is_gbc,
	bus_if.decode_mp                     bus,
	output logic [gb_io_pkg::ADDR_W-1:0] cart_addr,
	output logic [gb_io_pkg::DATA_W-1:0] cart_wdata,
	output logic                         cart_rd,
	output logic                         cart_wr,
	output logic [7:0]                   boot_addr
);
	import gb_io_pkg::*;

	region_e region_d;
	io_reg_e io_reg_d;
	logic    is_cart;

	// --------------------------------------
	// address classification
	// --------------------------------------
	always_comb begin
		region_d = RGN_NONE;
		io_reg_d = IO_NONE;
		case (cpu_addr)  // single-address registers
			ADDR_P1:   io_reg_d = IO_P1;
			ADDR_SB:   io_reg_d = IO_SB;
			ADDR_SC:   io_reg_d = IO_SC;
			ADDR_IF:   io_reg_d = IO_IF;
			ADDR_IE:   io_reg_d = IO_IE;
			ADDR_BOOT: io_reg_d = IO_BOOT;
			ADDR_SVBK: io_reg_d = is_gbc ? IO_SVBK : IO_NONE;  // dmg has no svbk
			default:   io_reg_d = IO_NONE;
		endcase
		if (cpu_addr <= ROM_END)
			region_d = RGN_ROM;
		else if (cpu_addr >= CRAM_BASE && cpu_addr <= CRAM_END)
			region_d = RGN_CRAM;
		else if (cpu_addr >= WRAM_BASE && cpu_addr <= WRAM_END)
			region_d = RGN_WRAM;
		else if (cpu_addr >= HRAM_BASE && cpu_addr <= HRAM_END)
			region_d = RGN_HRAM;
		else if (io_reg_d != IO_NONE)
			region_d = RGN_IO;
	end

	// stage register
	always_ff @(posedge clk_cpu) begin
		bus.addr  <= cpu_addr;
		bus.wdata <= cpu_wdata;
		if (reset) begin
			bus.rd     <= 1'b0;
			bus.wr     <= 1'b0;
			bus.region <= RGN_NONE;
			bus.io_reg <= IO_NONE;
		end else begin
			bus.rd     <= cpu_rd;
			bus.wr     <= cpu_wr;
			bus.region <= region_d;
			bus.io_reg <= io_reg_d;
		end
	end

	// cartridge side, valid for one cycle after the sampling edge
	assign is_cart    = (bus.region == RGN_ROM) || (bus.region == RGN_CRAM);
	assign cart_addr  = bus.addr;
	assign cart_wdata = bus.wdata;
	assign cart_rd    = bus.rd && is_cart;
	assign cart_wr    = bus.wr && is_cart;  // mbc register writes land here too
	assign boot_addr  = bus.addr[7:0];

endmodule

`default_nettype wire

//--- bus_if.sv
// --------------------------------------
// decoded cpu access, one per clock
// driven by addr_decode, consumed by the
// memory, i/o and read return stages
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
	import gb_io_pkg::*;

	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic              rd;      // one cycle per read
	logic              wr;      // one cycle per write
	region_e           region;
	io_reg_e           io_reg;  // IO_NONE unless region is RGN_IO

	modport decode_mp (
		output addr,
		output wdata,
		output rd,
		output wr,
		output region,
		output io_reg
	);

	modport stage_mp (
		input addr,
		input wdata,
		input rd,
		input wr,
		input region,
		input io_reg
	);

	// read return only needs to know what to pick
	modport return_mp (
		input rd,
		input region
	);

endinterface

`default_nettype wire

//--- byte_ram.sv
// --------------------------------------
// single port byte ram, synchronous read
// and write, depth set by ADDR_W
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
	parameter int ADDR_W = 7
) (
	input  wire                          clk_cpu,
	input  wire [ADDR_W-1:0]             addr,
	input  wire [gb_io_pkg::DATA_W-1:0]  wdata,
	input  wire                          wr,
	output logic [gb_io_pkg::DATA_W-1:0] rdata
);

	logic [gb_io_pkg::DATA_W-1:0] mem [0:(2**ADDR_W)-1];

	always_ff @(posedge clk_cpu) begin
		if (wr)
			mem[addr] <= wdata;
		rdata <= mem[addr];  // old data on a write cycle
	end

endmodule

`default_nettype wire

//--- gb_io_pkg.sv
// --------------------------------------
// shared types and constants for the bus
// and i/o side of the console
// imported by every stage and the bus_if
// --------------------------------------
`default_nettype none

package gb_io_pkg;

	// memory region of a decoded access
	typedef enum logic [2:0] {
		RGN_ROM,
		RGN_CRAM,
		RGN_WRAM,
		RGN_HRAM,
		RGN_IO,
		RGN_NONE
	} region_e;

	// addressed i/o register, IO_NONE outside the register set
	typedef enum logic [2:0] {
		IO_P1,
		IO_SB,
		IO_SC,
		IO_IF,
		IO_IE,
		IO_BOOT,
		IO_SVBK,
		IO_NONE
	} io_reg_e;

	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 8;
	localparam int HRAM_ADDR_W = 7;   // 127 bytes used
	localparam int WRAM_ADDR_W = 15;  // 8 banks of 4k
	localparam int IRQ_COUNT   = 5;

	// --------------------------------------
	// memory map
	// --------------------------------------
	localparam logic [15:0] ROM_END       = 16'h7FFF;
	localparam logic [15:0] BOOT_ROM_END  = 16'h00FF;  // boot rom overlay
	localparam logic [15:0] CRAM_BASE     = 16'hA000;
	localparam logic [15:0] CRAM_END      = 16'hBFFF;
	localparam logic [15:0] WRAM_BASE     = 16'hC000;
	localparam logic [15:0] WRAM_END      = 16'hFDFF;  // incl echo area
	localparam logic [15:0] HRAM_BASE     = 16'hFF80;
	localparam logic [15:0] HRAM_END      = 16'hFFFE;
	localparam logic [15:0] ADDR_P1       = 16'hFF00;
	localparam logic [15:0] ADDR_SB       = 16'hFF01;
	localparam logic [15:0] ADDR_SC       = 16'hFF02;
	localparam logic [15:0] ADDR_IF       = 16'hFF0F;
	localparam logic [15:0] ADDR_BOOT     = 16'hFF50;
	localparam logic [15:0] ADDR_SVBK     = 16'hFF70;  // colour mode only
	localparam logic [15:0] ADDR_IE       = 16'hFFFF;

	// interrupt vectors, source n at base + n * step
	localparam logic [7:0] IRQ_VEC_BASE   = 8'h40;
	localparam int         IRQ_VEC_STEP   = 8;
	localparam logic [7:0] IRQ_VEC_NONE   = 8'h55;

	localparam logic [7:0] FAST_BOOT_FLAG = 8'h42;  // seen by boot code at ff50
	localparam logic [7:0] BOOT_OFF_DMG   = 8'h01;  // any value with bit 0
	localparam logic [7:0] BOOT_OFF_GBC   = 8'h11;  // exact match in colour mode

endpackage

`default_nettype wire

//--- gb_io_top.sv
// --------------------------------------
// bus and i/o side of the console
// cpu access in, read data out two edges
// later; cartridge, boot rom, joypad and
// interrupt lines on plain ports
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gb_io_top #(
	parameter int SERIAL_DIV_W = 9
) (
	input  wire                          clk_cpu,
	input  wire                          reset,
	input  wire                          is_gbc,
	input  wire                          fast_boot,
	input  wire [7:0]                    joystick,
	input  wire                          vblank,
	input  wire                          lcd_irq,
	input  wire                          timer_irq,
	input  wire                          irq_ack,
	// cpu side
	input  wire [gb_io_pkg::ADDR_W-1:0]  cpu_addr,
	input  wire [gb_io_pkg::DATA_W-1:0]  cpu_wdata,
	input  wire                          cpu_rd,
	input  wire                          cpu_wr,
	output logic [gb_io_pkg::DATA_W-1:0] rdata,
	output logic                         rdata_valid,
	output logic                         irq_n,
	output logic [7:0]                   irq_vector,
	// cartridge and boot rom
	output logic [gb_io_pkg::ADDR_W-1:0] cart_addr,
	output logic [gb_io_pkg::DATA_W-1:0] cart_wdata,
	output logic                         cart_rd,
	output logic                         cart_wr,
	input  wire [gb_io_pkg::DATA_W-1:0]  cart_data,
	output logic [7:0]                   boot_addr,
	input  wire [gb_io_pkg::DATA_W-1:0]  boot_data
);
	import gb_io_pkg::*;

	logic [DATA_W-1:0] reg_rdata;
	logic [DATA_W-1:0] mem_rdata;
	logic              boot_enabled;
	logic [2:0]        wram_bank;

	bus_if bus ();

	addr_decode decode (
		.clk_cpu, .reset, .cpu_addr, .cpu_wdata, .cpu_rd, .cpu_wr, .is_gbc,
		.bus        (bus.decode_mp),
		.cart_addr, .cart_wdata, .cart_rd, .cart_wr, .boot_addr
	);

	io_regs #(.SERIAL_DIV_W(SERIAL_DIV_W)) regs (
		.clk_cpu, .reset, .is_gbc, .fast_boot, .joystick,
		.vblank, .lcd_irq, .timer_irq, .irq_ack,
		.bus        (bus.stage_mp),
		.reg_rdata, .boot_enabled, .wram_bank, .irq_n, .irq_vector
	);

	memory_stage mem (
		.clk_cpu, .reset,
		.bus        (bus.stage_mp),
		.boot_enabled, .wram_bank, .cart_data, .boot_data, .mem_rdata
	);

	read_return ret (
		.clk_cpu, .reset,
		.bus        (bus.return_mp),
		.reg_rdata, .mem_rdata, .rdata, .rdata_valid
	);

endmodule

`default_nettype wire

//--- io_regs.sv
// --------------------------------------
// stage 2 for i/o: joypad P1, dummy serial
// port, IF/IE with vector and ack, boot
// rom disable and the wram bank register
// writes land one edge after stage 1,
// reads are registered on the same edge
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module io_regs #(
	parameter int SERIAL_DIV_W = 9  // 9 bits gives roughly 8 kHz shift clock
) (
	input  wire                          clk_cpu,
	input  wire                          reset,
	input  wire                          is_gbc,
	input  wire                          fast_boot,
	input  wire [7:0]                    joystick,
	input  wire                          vblank,     // level
	input  wire                          lcd_irq,    // pulse
	input  wire                          timer_irq,  // pulse
	input  wire                          irq_ack,
	bus_if.stage_mp                      bus,
	output logic [gb_io_pkg::DATA_W-1:0] reg_rdata,
	output logic                         boot_enabled,
	output logic [2:0]                   wram_bank,
	output logic                         irq_n,
	output logic [7:0]                   irq_vector
);
	import gb_io_pkg::*;

	logic                    io_wr;
	logic [1:0]              p54;          // P1 select bits, low selects
	logic [3:0]              joy_p14;      // direction group
	logic [3:0]              joy_p15;      // button group
	logic [7:0]              joy_d;
	logic [7:0]              joy_d2;
	logic                    vs_d;
	logic                    vs_d2;
	logic                    sc_start;
	logic                    sc_int;       // internal shift clock
	logic [SERIAL_DIV_W-1:0] serial_div;
	logic [3:0]              serial_cnt;
	logic                    serial_irq;
	logic [IRQ_COUNT-1:0]    if_r;
	logic [IRQ_COUNT-1:0]    ie_r;
	logic [IRQ_COUNT-1:0]    pending;
	logic [IRQ_COUNT-1:0]    ack_mask;
	logic [IRQ_COUNT-1:0]    irq_set;

	assign io_wr = bus.wr && (bus.region == RGN_IO);

	// --------------------------------------
	// joypad
	// --------------------------------------
	assign joy_p14 = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_p15 = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	always_ff @(posedge clk_cpu) begin
		if (reset)
			p54 <= 2'b00;
		else if (io_wr && bus.io_reg == IO_P1)
			p54 <= bus.wdata[5:4];
	end

	// --------------------------------------
	// serial port, no partner attached
	// --------------------------------------
	always_ff @(posedge clk_cpu) begin
		serial_irq <= 1'b0;
		if (reset) begin
			sc_start   <= 1'b0;
			sc_int     <= 1'b0;
			serial_div <= '1;
			serial_cnt <= 4'd8;
		end else if (io_wr && bus.io_reg == IO_SC) begin
			sc_start <= bus.wdata[7];
			sc_int   <= bus.wdata[0];
			if (bus.wdata[7]) begin  // new transfer
				serial_div <= '1;
				serial_cnt <= 4'd8;
			end
		end else if (sc_start && sc_int) begin
			serial_div <= serial_div - 1'b1;
			if (serial_div == '0 && serial_cnt != 4'd0)
				serial_cnt <= serial_cnt - 4'd1;  // one bit shifted out
			if (serial_cnt == 4'd0) begin
				serial_irq <= 1'b1;  // byte done
				sc_start   <= 1'b0;
				serial_div <= '1;
				serial_cnt <= 4'd8;
			end
		end
	end

	// --------------------------------------
	// interrupt controller
	// --------------------------------------
	assign pending  = if_r & ie_r;
	assign ack_mask = pending & (~pending + 1'b1);  // lowest set bit only
	assign irq_set  = {|(~joy_d & joy_d2), serial_irq, timer_irq, lcd_irq, vs_d & ~vs_d2};
	assign irq_n    = ~|pending;

	always_comb begin
		irq_vector = IRQ_VEC_NONE;
		for (int i = IRQ_COUNT - 1; i >= 0; i--) begin  // lowest index wins
			if (pending[i])
				irq_vector = IRQ_VEC_BASE + 8'(i * IRQ_VEC_STEP);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			vs_d   <= 1'b0;
			vs_d2  <= 1'b0;
			joy_d  <= 8'hFF;  // released lines read high
			joy_d2 <= 8'hFF;
			if_r   <= '0;
			ie_r   <= '0;
		end else begin
			vs_d   <= vblank;
			vs_d2  <= vs_d;
			joy_d  <= {joy_p14, joy_p15};
			joy_d2 <= joy_d;
			// a new event beats an ack on the same bit
			if_r <= (if_r & ~(irq_ack ? ack_mask : '0)) | irq_set;
			if (io_wr && bus.io_reg == IO_IF)
				if_r <= bus.wdata[IRQ_COUNT-1:0];  // cpu write overrides
			if (io_wr && bus.io_reg == IO_IE)
				ie_r <= bus.wdata[IRQ_COUNT-1:0];
		end
	end

	// --------------------------------------
	// boot rom disable and wram bank
	// --------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			boot_enabled <= 1'b1;
			wram_bank    <= 3'd1;
		end else if (io_wr) begin
			if (bus.io_reg == IO_BOOT) begin
				if ((is_gbc && bus.wdata == BOOT_OFF_GBC) ||
				    (!is_gbc && (bus.wdata & BOOT_OFF_DMG) != '0))
					boot_enabled <= 1'b0;  // cannot be turned back on
			end
			if (bus.io_reg == IO_SVBK)
				wram_bank <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0];
		end
	end

	// registered read of the addressed register
	always_ff @(posedge clk_cpu) begin
		case (bus.io_reg)
			IO_P1:   reg_rdata <= {2'b11, p54, joy_p14 & joy_p15};
			IO_SB:   reg_rdata <= 8'hFF;  // nothing ever shifted in
			IO_SC:   reg_rdata <= {sc_start, 6'h3F, sc_int};
			IO_IF:   reg_rdata <= {{(DATA_W - IRQ_COUNT){1'b1}}, if_r};
			IO_IE:   reg_rdata <= {{(DATA_W - IRQ_COUNT){1'b0}}, ie_r};
			IO_BOOT: reg_rdata <= (fast_boot && boot_enabled) ? FAST_BOOT_FLAG : 8'hFF;
			IO_SVBK: reg_rdata <= {5'h1F, wram_bank};
			default: reg_rdata <= 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- memory_stage.sv
// --------------------------------------
// stage 2 for memory: high ram, banked
// work ram and capture of cartridge or
// boot rom data on the stage edge
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire                          clk_cpu,
	input  wire                          reset,
	bus_if.stage_mp                      bus,
	input  wire                          boot_enabled,
	input  wire [2:0]                    wram_bank,
	input  wire [gb_io_pkg::DATA_W-1:0]  cart_data,
	input  wire [gb_io_pkg::DATA_W-1:0]  boot_data,
	output logic [gb_io_pkg::DATA_W-1:0] mem_rdata
);
	import gb_io_pkg::*;

	logic [WRAM_ADDR_W-1:0] wram_addr;
	logic [DATA_W-1:0]      hram_q;
	logic [DATA_W-1:0]      wram_q;
	logic [DATA_W-1:0]      rom_q;     // cart or boot byte
	region_e                region_q;

	// d000-dfff (and its echo) is the switchable bank
	assign wram_addr = {bus.addr[12] ? wram_bank : 3'd0, bus.addr[11:0]};

	byte_ram #(.ADDR_W(HRAM_ADDR_W)) hram (
		.clk_cpu (clk_cpu),
		.addr    (bus.addr[HRAM_ADDR_W-1:0]),
		.wdata   (bus.wdata),
		.wr      (bus.wr && bus.region == RGN_HRAM),
		.rdata   (hram_q)
	);

	byte_ram #(.ADDR_W(WRAM_ADDR_W)) wram (
		.clk_cpu (clk_cpu),
		.addr    (wram_addr),
		.wdata   (bus.wdata),
		.wr      (bus.wr && bus.region == RGN_WRAM),
		.rdata   (wram_q)
	);

	always_ff @(posedge clk_cpu) begin
		if (boot_enabled && bus.addr <= BOOT_ROM_END)
			rom_q <= boot_data;  // boot rom overlays 0000-00ff
		else
			rom_q <= cart_data;
		region_q <= reset ? RGN_NONE : bus.region;
	end

	// pick by the region that went with these reads
	always_comb begin
		case (region_q)
			RGN_HRAM: mem_rdata = hram_q;
			RGN_WRAM: mem_rdata = wram_q;
			default:  mem_rdata = rom_q;  // rom and cart ram
		endcase
	end

endmodule

`default_nettype wire

//--- project.f
gb_io_pkg.sv
bus_if.sv
addr_decode.sv
io_regs.sv
byte_ram.sv
memory_stage.sv
read_return.sv
gb_io_top.sv
tb_gb_io.sv

//--- read_return.sv
// --------------------------------------
// stage 3: picks i/o or memory data for
// the read that left stage 2 and returns
// it with a one cycle valid pulse
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module read_return (
	input  wire                          clk_cpu,
	input  wire                          reset,
	bus_if.return_mp                     bus,
	input  wire [gb_io_pkg::DATA_W-1:0]  reg_rdata,
	input  wire [gb_io_pkg::DATA_W-1:0]  mem_rdata,
	output logic [gb_io_pkg::DATA_W-1:0] rdata,
	output logic                         rdata_valid
);
	import gb_io_pkg::*;

	logic    rd_q;
	region_e region_q;

	// line up with the stage 2 registers
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			rd_q     <= 1'b0;
			region_q <= RGN_NONE;
		end else begin
			rd_q     <= bus.rd;
			region_q <= bus.region;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (reset)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= rd_q;
		case (region_q)
			RGN_IO:   rdata <= reg_rdata;
			RGN_NONE: rdata <= 8'hFF;  // open bus
			default:  rdata <= mem_rdata;
		endcase
	end

endmodule

`default_nettype wire

//--- tb_gb_io.sv
// --------------------------------------
// testbench for the bus and i/o side
// plays the cpu, one access per clock,
// with cart and boot rom models; read
// data is checked two edges after issue
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_gb_io;
	import gb_io_pkg::*;

	localparam int SERIAL_DIV_W = 4;
	localparam int SERIAL_BOUND = 9 * (2 ** SERIAL_DIV_W) + 8;  // eight wraps plus slack
	localparam int MAX_CYCLES   = 20000;  // whole run needs under 2000

	logic        clk_cpu;
	logic        reset;
	logic        is_gbc;
	logic        fast_boot;
	logic [7:0]  joystick;
	logic        vblank;
	logic        lcd_irq;
	logic        timer_irq;
	logic        irq_ack;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_rd;
	logic        cpu_wr;
	logic [7:0]  rdata;
	logic        rdata_valid;
	logic        irq_n;
	logic [7:0]  irq_vector;
	logic [15:0] cart_addr;
	logic [7:0]  cart_wdata;
	logic        cart_rd;
	logic        cart_wr;
	logic [7:0]  cart_data;
	logic [7:0]  boot_addr;
	logic [7:0]  boot_data;

	logic [7:0]  exp_q[$];     // expected read data, oldest first
	logic [2:0]  rd_pipe;      // issued reads, one bit per edge
	logic [7:0]  exp_v;
	logic [7:0]  wram_ref [0:(2**WRAM_ADDR_W)-1];  // indexed by {bank, offset}
	logic [7:0]  hram_ref [0:(2**HRAM_ADDR_W)-1];
	logic [18:0] wlist[$];     // {bank, addr} of every wram write
	logic [6:0]  hlist[$];
	int          errors;
	int          checks;
	int          cycles;
	int          err_start;
	int unsigned seed;

	gb_io_top #(.SERIAL_DIV_W(SERIAL_DIV_W)) uut (.*);

	// --------------------------------------
	// models
	// --------------------------------------
	function automatic logic [7:0] cart_model(input logic [15:0] a);
		cart_model = a[15:8] ^ {a[6:0], a[7]} ^ 8'hA5;
	endfunction

	function automatic logic [7:0] boot_model(input logic [7:0] a);
		boot_model = {a[3:0], a[7:4]} ^ 8'hC3;
	endfunction

	// direction group is up down left right, button group is start select b a
	function automatic logic [7:0] p1_model(input logic [1:0] sel, input logic [7:0] joy);
		logic [3:0] dir_pressed;
		logic [3:0] btn_pressed;
		logic [3:0] lines;
		dir_pressed = {joy[2], joy[3], joy[1], joy[0]};  // p13 down .. p10 right
		btn_pressed = joy[7:4];
		lines       = 4'hF;  // released lines read high
		for (int i = 0; i < 4; i++) begin
			if (!sel[0] && dir_pressed[i])
				lines[i] = 1'b0;  // low select bit enables the group
			if (!sel[1] && btn_pressed[i])
				lines[i] = 1'b0;
		end
		p1_model = {2'b11, sel, lines};
	endfunction

	function automatic logic [7:0] vector_model(input logic [4:0] pend);
		logic found;
		found = 1'b0;
		vector_model = IRQ_VEC_NONE;
		for (int i = 0; i < IRQ_COUNT; i++) begin
			if (pend[i] && !found) begin
				vector_model = IRQ_VEC_BASE + 8'(i * IRQ_VEC_STEP);
				found = 1'b1;
			end
		end
	endfunction

	assign cart_data = cart_model(cart_addr);
	assign boot_data = boot_model(boot_addr);

	initial begin
		clk_cpu = 1'b0;
		forever #2 clk_cpu = ~clk_cpu;
	end

	always @(posedge clk_cpu) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// --------------------------------------
	// read return checker
	// --------------------------------------
	always @(posedge clk_cpu) begin
		if (reset)
			rd_pipe <= 3'b000;
		else
			rd_pipe <= {rd_pipe[1:0], cpu_rd};
	end

	always @(negedge clk_cpu) begin
		if (!reset) begin
			check_eq("rdata_valid", rdata_valid, rd_pipe[2]);  // one pulse per read
			if (rd_pipe[2]) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					$display("read data came back with no read outstanding");
					errors++;
				end
				if (exp_q.size() != 0) begin
					exp_v = exp_q.pop_front();
					check_eq("rdata", rdata, exp_v);
				end
			end
		end
	end

	task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error at %0t: %s expected %0h got %0h", $time, name, exp, got);
			errors++;
		end
	endtask

	// all bus tasks start and end on a falling edge
	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		cpu_addr  = a;
		cpu_wdata = d;
		cpu_wr    = 1'b1;
		@(negedge clk_cpu);
		cpu_wr = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] a, input logic [7:0] exp);
		cpu_addr = a;
		cpu_rd   = 1'b1;
		exp_q.push_back(exp);
		@(negedge clk_cpu);
		cpu_rd = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk_cpu);
	endtask

	task automatic wait_irq_low(input int bound, input string what);
		int n;
		n = 0;
		while (irq_n !== 1'b0 && n < bound) begin
			@(negedge clk_cpu);
			n++;
		end
		checks++;
		assert (irq_n === 1'b0) else begin
			$display("%s: irq_n stayed high for %0d cycles", what, bound);
			errors++;
		end
	endtask

	// ack pulse clears the lowest pending enabled bit in the model
	task automatic ack_lowest(inout logic [4:0] if_exp, input logic [4:0] ie_exp);
		logic done;
		done    = 1'b0;
		irq_ack = 1'b1;
		@(negedge clk_cpu);
		irq_ack = 1'b0;
		for (int i = 0; i < IRQ_COUNT; i++) begin
			if (if_exp[i] && ie_exp[i] && !done) begin
				if_exp[i] = 1'b0;
				done      = 1'b1;
			end
		end
		check_eq("irq_vector", irq_vector, vector_model(if_exp & ie_exp));
		check_eq("irq_n", irq_n, ~|(if_exp & ie_exp));
	endtask

	task automatic report_test(input string name);
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_start);
		err_start = errors;
	endtask

	// --------------------------------------
	// tests
	// --------------------------------------
	task automatic ram_banks();
		logic [15:0] a;
		logic [7:0]  d;
		for (int i = 0; i < 16; i++) begin
			a = HRAM_BASE + 16'($urandom % 127);
			d = 8'($urandom);
			bus_write(a, d);
			hram_ref[int'(a[6:0])] = d;
			hlist.push_back(a[6:0]);
			if (i % 4 == 0)
				bus_read(a, d);  // right behind the write
		end
		for (int i = 0; i < 8; i++) begin  // fixed bank c000-cfff
			a = WRAM_BASE | 16'($urandom & 32'h0FFF);
			d = 8'($urandom);
			bus_write(a, d);
			wram_ref[int'({3'd0, a[11:0]})] = d;
			wlist.push_back({3'd0, a});
		end
		for (int b = 1; b < 8; b++) begin
			bus_write(ADDR_SVBK, 8'(b));
			for (int i = 0; i < 4; i++) begin
				a = 16'hD000 | 16'($urandom & 32'h0FFF);
				d = 8'($urandom);
				bus_write(a, d);
				wram_ref[int'({3'(b), a[11:0]})] = d;
				wlist.push_back({3'(b), a});
			end
		end
		for (int b = 1; b < 8; b++) begin
			bus_write(ADDR_SVBK, 8'(b));
			foreach (wlist[j])
				if (wlist[j][18:16] == 3'(b))
					bus_read(wlist[j][15:0], wram_ref[int'({wlist[j][18:16], wlist[j][11:0]})]);
		end
		foreach (wlist[j])
			if (wlist[j][18:16] == 3'd0)
				bus_read(wlist[j][15:0], wram_ref[int'({3'd0, wlist[j][11:0]})]);
		foreach (hlist[j])
			bus_read({9'h1FF, hlist[j]}, hram_ref[int'(hlist[j])]);
		bus_write(ADDR_SVBK, 8'h00);  // bank 0 maps to bank 1
		bus_read(wlist[8][15:0], wram_ref[int'({3'd1, wlist[8][11:0]})]);
		wait_drain();
	endtask

	task automatic boot_and_cart();
		logic [15:0] a;
		for (int i = 0; i < 6; i++) begin
			a = 16'($urandom % 256);
			bus_read(a, boot_model(a[7:0]));
			a = 16'h0100 + 16'($urandom % 32'h7F00);
			bus_read(a, cart_model(a));
		end
		a = CRAM_BASE + 16'($urandom % 32'h2000);
		bus_read(a, cart_model(a));
		bus_read(ADDR_BOOT, FAST_BOOT_FLAG);
		bus_read(16'hFF4D, 8'hFF);  // unmapped register, open bus
		bus_write(ADDR_BOOT, BOOT_OFF_GBC);
		for (int i = 0; i < 6; i++) begin
			a = 16'($urandom % 256);
			bus_read(a, cart_model(a));  // overlay gone
		end
		wait_drain();
		bus_write(16'h2000, 8'h05);  // mbc style write
		check_eq("cart_wr", cart_wr, 1'b1);
		check_eq("cart_rd", cart_rd, 1'b0);
		check_eq("cart_wdata", cart_wdata, 8'h05);
		check_eq("cart_addr", cart_addr, 16'h2000);
		@(negedge clk_cpu);
		check_eq("cart_wr", cart_wr, 1'b0);
		bus_read(16'h4000, cart_model(16'h4000));
		check_eq("cart_rd", cart_rd, 1'b1);  // strobe while the read sits in stage 1
		check_eq("cart_addr", cart_addr, 16'h4000);
		wait_drain();
	endtask

	task automatic joypad_lines();
		for (int s = 0; s < 4; s++) begin
			joystick = 8'($urandom);
			bus_write(ADDR_P1, {2'b00, 2'(s), 4'h0});
			bus_read(ADDR_P1, p1_model(2'(s), joystick));
			wait_drain();  // joystick held until the read is back
		end
		joystick = 8'h00;
		bus_write(ADDR_P1, 8'h20);  // directions selected
		repeat (4) @(negedge clk_cpu);  // edge detector settles
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h10);
		bus_read(ADDR_IF, 8'hE0);
		wait_drain();
		check_eq("irq_n", irq_n, 1'b1);
		joystick = 8'h01;  // press right
		wait_irq_low(8, "joypad");
		check_eq("irq_vector", irq_vector, vector_model(5'b10000));
		bus_read(ADDR_IF, 8'hF0);
		bus_write(ADDR_IE, 8'h00);
		wait_drain();
		joystick = 8'h00;
	endtask

	task automatic irq_priority();
		logic [4:0] if_exp;
		logic [4:0] ie_exp;
		bus_write(ADDR_IE, 8'hFF);
		bus_read(ADDR_IE, 8'h1F);  // upper bits read low
		bus_write(ADDR_IF, 8'h00);
		bus_read(ADDR_IF, 8'hE0);  // upper bits read high
		bus_write(ADDR_IE, 8'h06);
		wait_drain();
		vblank = 1'b1;
		repeat (3) @(negedge clk_cpu);
		check_eq("irq_n", irq_n, 1'b1);  // vblank not enabled
		lcd_irq   = 1'b1;
		timer_irq = 1'b1;
		@(negedge clk_cpu);
		lcd_irq   = 1'b0;
		timer_irq = 1'b0;
		wait_irq_low(4, "lcd and timer");
		if_exp = 5'b00111;
		ie_exp = 5'b00110;
		check_eq("irq_vector", irq_vector, vector_model(if_exp & ie_exp));
		ack_lowest(if_exp, ie_exp);  // masked vblank bit must survive
		bus_read(ADDR_IF, {3'b111, if_exp});
		bus_write(ADDR_IE, 8'h07);
		ie_exp = 5'b00111;
		wait_drain();
		check_eq("irq_vector", irq_vector, vector_model(if_exp & ie_exp));
		while ((if_exp & ie_exp) != 5'd0)
			ack_lowest(if_exp, ie_exp);
		bus_read(ADDR_IF, 8'hE0);
		bus_write(ADDR_IE, 8'h00);
		wait_drain();
		vblank = 1'b0;
	endtask

	task automatic serial_transfer();
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h08);
		bus_write(ADDR_SC, 8'h81);  // start, internal clock
		wait_irq_low(SERIAL_BOUND, "serial");
		bus_read(ADDR_SC, 8'h7F);  // start clear, clock kept
		bus_read(ADDR_SB, 8'hFF);
		bus_read(ADDR_IF, 8'hE8);
		bus_write(ADDR_IF, 8'h00);
		bus_write(ADDR_IE, 8'h00);
		wait_drain();
	endtask

	initial begin
		seed      = $urandom(88);
		errors    = 0;
		checks    = 0;
		cycles    = 0;
		err_start = 0;
		reset     = 1'b1;
		is_gbc    = 1'b1;
		fast_boot = 1'b1;
		joystick  = 8'h00;
		vblank    = 1'b0;
		lcd_irq   = 1'b0;
		timer_irq = 1'b0;
		irq_ack   = 1'b0;
		cpu_addr  = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_rd    = 1'b0;
		cpu_wr    = 1'b0;
		repeat (16) @(negedge clk_cpu);
		reset = 1'b0;
		check_eq("irq_n", irq_n, 1'b1);
		check_eq("cart_rd", cart_rd, 1'b0);
		check_eq("cart_wr", cart_wr, 1'b0);
		report_test("reset");
		ram_banks();
		report_test("ram");
		boot_and_cart();
		report_test("boot and cart");
		joypad_lines();
		report_test("joypad");
		irq_priority();
		report_test("interrupts");
		serial_transfer();
		report_test("serial");
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
